// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := route_stage_tb
FILELIST := all.f
OBJ_DIR := obj_dir
LOG := sim.log

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
rtl/route_pkg.sv
rtl/instruction_route.sv
rtl/operand_route.sv
rtl/dispatch_combine.sv
rtl/route_stage.sv
tb/route_stage_sva.sv
tb/route_stage_tb.sv

// File: rtl/dispatch_combine.sv
module dispatch_combine import route_pkg::*; (
	input logic clk,
	input logic rst_n,
	input decoded_instr_t instr,
	input route_t route,
	input operands_t ops,
	output dispatch_t dispatch
);

	// return address, compressed instructions step by 2
	logic [XLEN-1:0] next_pc;
	assign next_pc = instr.pc + (instr.length ? XLEN'(4) : XLEN'(2));

	// control class without a compare, JAL or JALR
	logic is_jump;
	assign is_jump = (instr.instruction_type == ITYPE_CTRL) && !instr.branch;

	// JAL has no work for a functional unit
	logic is_jal;
	assign is_jal = is_jump && !instr.jalr;

	// store whose data came straight from the register file
	logic store_data_ready;
	assign store_data_ready = (instr.instruction_type == ITYPE_STORE)
		&& !instr.rs2_rob_tag_valid;

	// value the new ROB entry starts with
	logic [XLEN-1:0] rob_value_d;

	always_comb begin
		if (is_jump) begin
			// JALR still executes for its target, link value is known now
			rob_value_d = next_pc;
		end else if (instr.lui) begin
			rob_value_d = instr.immediate;
		end else if (instr.auipc) begin
			rob_value_d = instr.pc + instr.immediate;
		end else if (store_data_ready) begin
			rob_value_d = instr.rs2;
		end else begin
			rob_value_d = '0;
		end
	end

	// entry complete at allocation
	// alloc_rob already carries valid, flush and stall
	logic rob_data_ready_d;
	assign rob_data_ready_d = route.alloc_rob
		&& (is_jal || instr.lui || instr.auipc || store_data_ready);

	// control part of the record
	route_t route_q;
	logic rob_data_ready_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			route_q <= '0;
			rob_data_ready_q <= 1'b0;
		end else begin
			route_q <= route;
			rob_data_ready_q <= rob_data_ready_d;
		end
	end

	// payload part, only meaningful alongside a strobe
	operands_t ops_q;
	logic [XLEN-1:0] rob_value_q;

	always_ff @(posedge clk) begin
		ops_q <= ops;
		rob_value_q <= rob_value_d;
	end

	assign dispatch = '{
		route: route_q,
		ops: ops_q,
		rob_value: rob_value_q,
		rob_data_ready: rob_data_ready_q
	};

endmodule

// File: rtl/instruction_route.sv
module instruction_route import route_pkg::*; (
	input decoded_instr_t instr,
	input resource_status_t status,
	output route_t route,
	output logic stall
);

	// station class of this instruction
	logic is_alu;
	logic is_agu;
	logic is_branch;

	// u-type values are known already, they go straight to the ROB
	assign is_alu = (instr.instruction_type == ITYPE_ALU) && !instr.u_type;
	// loads and stores both need an address
	assign is_agu = instr.instruction_type[1];
	// JAL has nothing left to execute, only branch and JALR go to the unit
	assign is_branch = (instr.instruction_type == ITYPE_CTRL)
		&& (instr.branch || instr.jalr);

	// free stations per class
	logic [N_ALU_RS-1:0] alu_free;
	logic [N_AGU_RS-1:0] agu_free;
	logic [N_BRANCH_RS-1:0] branch_free;

	assign alu_free = ~status.alu_rs_busy;
	assign agu_free = ~status.agu_rs_busy;
	assign branch_free = ~status.branch_rs_busy;

	// lowest set bit, x & -x keeps only the least significant one
	logic [N_ALU_RS-1:0] alu_pick;
	logic [N_AGU_RS-1:0] agu_pick;
	logic [N_BRANCH_RS-1:0] branch_pick;

	assign alu_pick = alu_free & (~alu_free + N_ALU_RS'(1));
	assign agu_pick = agu_free & (~agu_free + N_AGU_RS'(1));
	assign branch_pick = branch_free & (~branch_free + N_BRANCH_RS'(1));

	// stall reasons, valid is left out so it joins only at the very end
	logic need_full;
	logic no_station;
	logic stall_any;

	// a buffer matters only if this instruction wants an entry in it
	assign need_full = (instr.alloc_rob && status.rob_full)
		|| (instr.alloc_ldq && status.ldq_full)
		|| (instr.alloc_stq && status.stq_full);
	// every station of the needed class taken
	assign no_station = (is_alu && (&status.alu_rs_busy))
		|| (is_agu && (&status.agu_rs_busy))
		|| (is_branch && (&status.branch_rs_busy));
	assign stall_any = need_full || no_station;

	// a flushed instruction is dropped, so it never holds up the pipe
	assign stall = instr.valid && (!instr.flush && stall_any);

	// nothing leaves on a flush or a stall
	logic go;
	assign go = !instr.flush && !stall_any;

	always_comb begin
		route.alloc_rob = instr.valid && (instr.alloc_rob && go);
		route.alloc_ldq = instr.valid && (instr.alloc_ldq && go);
		route.alloc_stq = instr.valid && (instr.alloc_stq && go);
		// each select masked to its own width
		route.alu_rs_route = alu_pick
			& {N_ALU_RS{is_alu}}
			& {N_ALU_RS{go}}
			& {N_ALU_RS{instr.valid}};
		route.agu_rs_route = agu_pick
			& {N_AGU_RS{is_agu}}
			& {N_AGU_RS{go}}
			& {N_AGU_RS{instr.valid}};
		route.branch_rs_route = branch_pick
			& {N_BRANCH_RS{is_branch}}
			& {N_BRANCH_RS{go}}
			& {N_BRANCH_RS{instr.valid}};
	end

endmodule

// File: rtl/operand_route.sv
module operand_route import route_pkg::*; (
	input decoded_instr_t instr,
	input rob_view_t rob,
	output operands_t ops
);

	// ROB entry named by each source tag has its result already
	logic rs1_fwd_ready;
	logic rs2_fwd_ready;

	assign rs1_fwd_ready = rob.data_ready[instr.rs1_rob_tag];
	assign rs2_fwd_ready = rob.data_ready[instr.rs2_rob_tag];

	// resolved rs1, either a value or a tag to watch for
	logic q1_valid_rs1;
	logic [ROB_TAG_WIDTH-1:0] q1_rs1;
	logic [XLEN-1:0] v1_rs1;

	// wait only when the producer is still in flight
	assign q1_valid_rs1 = instr.rs1_rob_tag_valid && !rs1_fwd_ready;
	assign q1_rs1 = q1_valid_rs1 ? instr.rs1_rob_tag : '0;
	// register file, then ROB forward, else zero while waiting
	assign v1_rs1 = !instr.rs1_rob_tag_valid ? instr.rs1
		: rs1_fwd_ready ? rob.value[instr.rs1_rob_tag]
		: '0;

	// resolved rs2, same rules
	logic q2_valid_rs2;
	logic [ROB_TAG_WIDTH-1:0] q2_rs2;
	logic [XLEN-1:0] v2_rs2;

	assign q2_valid_rs2 = instr.rs2_rob_tag_valid && !rs2_fwd_ready;
	assign q2_rs2 = q2_valid_rs2 ? instr.rs2_rob_tag : '0;
	assign v2_rs2 = !instr.rs2_rob_tag_valid ? instr.rs2
		: rs2_fwd_ready ? rob.value[instr.rs2_rob_tag]
		: '0;

	// operand 1
	always_comb begin
		ops.q1_valid = 1'b0;
		ops.q1 = '0;
		case (instr.opcode)
			// pc relative, operand 1 is the pc itself
			OP_JAL, OP_AUIPC: begin
				ops.v1 = instr.pc;
			end
			// LUI needs no base, a bubble goes nowhere
			OP_LUI, OP_BUBBLE: begin
				ops.v1 = '0;
			end
			default: begin
				ops.q1_valid = q1_valid_rs1;
				ops.q1 = q1_rs1;
				ops.v1 = v1_rs1;
			end
		endcase
	end

	// operand 2
	always_comb begin
		ops.q2_valid = 1'b0;
		ops.q2 = '0;
		case (instr.opcode)
			// register-register forms
			OP_R_TYPE, OP_BRANCH: begin
				ops.q2_valid = q2_valid_rs2;
				ops.q2 = q2_rs2;
				ops.v2 = v2_rs2;
			end
			OP_BUBBLE: begin
				ops.v2 = '0;
			end
			// stores carry their offset here, the data goes via the ROB value
			default: begin
				ops.v2 = instr.immediate;
			end
		endcase
	end

endmodule

// File: rtl/route_pkg.sv
package route_pkg;

	// machine and buffer sizes
	localparam int XLEN = 32;
	localparam int N_ALU_RS = 4;
	localparam int N_AGU_RS = 2;
	localparam int N_BRANCH_RS = 2;
	localparam int ROB_SIZE = 16;
	localparam int ROB_TAG_WIDTH = 4;

	// base opcodes, bits [6:0] of the instruction word
	localparam logic [6:0] OP_R_TYPE = 7'b0110011;
	localparam logic [6:0] OP_I_ALU = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	// bubble inserted by decode, routed nowhere
	localparam logic [6:0] OP_BUBBLE = 7'b0000000;

	// instruction class as seen by commit
	localparam logic [1:0] ITYPE_ALU = 2'b00;
	localparam logic [1:0] ITYPE_CTRL = 2'b01;
	localparam logic [1:0] ITYPE_LOAD = 2'b10;
	localparam logic [1:0] ITYPE_STORE = 2'b11;

	// one decoded instruction plus its register file read results
	typedef struct packed {
		logic valid;
		logic flush;
		logic [6:0] opcode;
		logic [1:0] instruction_type;
		logic branch;
		logic jalr;
		logic u_type;
		logic lui;
		logic auipc;
		logic alloc_rob;
		logic alloc_ldq;
		logic alloc_stq;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] immediate;
		// 1 for a 4 byte instruction, 0 for a compressed one
		logic length;
		logic [XLEN-1:0] rs1;
		logic [ROB_TAG_WIDTH-1:0] rs1_rob_tag;
		logic rs1_rob_tag_valid;
		logic [XLEN-1:0] rs2;
		logic [ROB_TAG_WIDTH-1:0] rs2_rob_tag;
		logic rs2_rob_tag_valid;
	} decoded_instr_t;

	// fullness of the downstream buffers and stations
	typedef struct packed {
		logic rob_full;
		logic ldq_full;
		logic stq_full;
		logic [N_ALU_RS-1:0] alu_rs_busy;
		logic [N_AGU_RS-1:0] agu_rs_busy;
		logic [N_BRANCH_RS-1:0] branch_rs_busy;
	} resource_status_t;

	// ROB contents that can be forwarded
	typedef struct packed {
		logic [ROB_SIZE-1:0][XLEN-1:0] value;
		logic [ROB_SIZE-1:0] data_ready;
	} rob_view_t;

	// allocate strobes and one-hot station selects
	typedef struct packed {
		logic alloc_rob;
		logic alloc_ldq;
		logic alloc_stq;
		logic [N_ALU_RS-1:0] alu_rs_route;
		logic [N_AGU_RS-1:0] agu_rs_route;
		logic [N_BRANCH_RS-1:0] branch_rs_route;
	} route_t;

	// source operands, value or tag to wait on
	typedef struct packed {
		logic q1_valid;
		logic [ROB_TAG_WIDTH-1:0] q1;
		logic [XLEN-1:0] v1;
		logic q2_valid;
		logic [ROB_TAG_WIDTH-1:0] q2;
		logic [XLEN-1:0] v2;
	} operands_t;

	// registered output of the stage
	typedef struct packed {
		route_t route;
		operands_t ops;
		logic [XLEN-1:0] rob_value;
		logic rob_data_ready;
	} dispatch_t;

endpackage

// File: rtl/route_stage.sv
module route_stage import route_pkg::*; (
	input logic clk,
	input logic rst_n,
	input decoded_instr_t instr,
	input resource_status_t status,
	input rob_view_t rob,
	output logic stall,
	output dispatch_t dispatch
);

	// station choice and allocate strobes
	route_t route;
	// resolved source operands
	operands_t ops;

	// resources and stall
	instruction_route instruction_route_i (
		.instr(instr),
		.status(status),
		.route(route),
		.stall(stall)
	);

	// operands, runs beside the resource check
	operand_route operand_route_i (
		.instr(instr),
		.rob(rob),
		.ops(ops)
	);

	// ROB start value and the output register
	dispatch_combine dispatch_combine_i (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.route(route),
		.ops(ops),
		.dispatch(dispatch)
	);

endmodule

// File: tb/route_stage_sva.sv
module route_stage_sva import route_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input dispatch_t dispatch
);

	timeunit 1ns;
	timeprecision 100ps;

	// at most one station per class
	alu_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(dispatch.route.alu_rs_route))
		else $error("more than one ALU station selected");
	agu_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(dispatch.route.agu_rs_route))
		else $error("more than one AGU station selected");
	branch_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(dispatch.route.branch_rs_route))
		else $error("more than one branch station selected");

	// a stalled instruction leaves an empty record behind
	empty_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> dispatch.route == '0)
		else $error("strobe set in the cycle after a stall");

	// record held empty in reset
	empty_in_reset: assert property (@(posedge clk)
		!rst_n |-> (dispatch.route == '0) && !dispatch.rob_data_ready)
		else $error("strobe set while in reset");

endmodule

bind route_stage route_stage_sva route_stage_sva_i (
	.clk(clk),
	.rst_n(rst_n),
	.stall(stall),
	.dispatch(dispatch)
);

// File: tb/route_stage_tb.sv
module route_stage_tb import route_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int N_MIXED = 400;
	localparam int N_KILL = 150;
	localparam int N_STALL = 250;
	// one drain cycle per test, a few spare cycles and some slack
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + N_MIXED + N_KILL + N_STALL + 8) * CLK_PERIOD + 100;
	// x^32 + x^22 + x^2 + x + 1 in right shifting form
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic clk;
	logic rst_n;
	decoded_instr_t instr;
	resource_status_t status;
	rob_view_t rob;
	logic stall;
	dispatch_t dispatch;

	logic [31:0] lfsr = 32'h77f7_c74d;
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_run = 0;

	route_stage route_stage_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// n bits, one LFSR step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
		end
		return bits;
	endfunction

	// true with probability 1 in 2**n
	function automatic logic biased(input int n);
		return take_bits(n) == 0;
	endfunction

	// mode 0 mixed, 1 many kills, 2 many full buffers and busy stations
	task automatic make_inputs(input int mode);
		int sel;
		instr = '0;
		sel = int'(take_bits(4)) % 10;
		case (sel)
			0: instr.opcode = OP_R_TYPE;
			1: instr.opcode = OP_I_ALU;
			2: instr.opcode = OP_LOAD;
			3: instr.opcode = OP_STORE;
			4: instr.opcode = OP_BRANCH;
			5: instr.opcode = OP_JALR;
			6: instr.opcode = OP_JAL;
			7: instr.opcode = OP_LUI;
			8: instr.opcode = OP_AUIPC;
			default: instr.opcode = OP_BUBBLE;
		endcase
		// class and control bits follow from the opcode
		instr.instruction_type = (instr.opcode == OP_LOAD) ? ITYPE_LOAD
			: (instr.opcode == OP_STORE) ? ITYPE_STORE
			: (instr.opcode inside {OP_BRANCH, OP_JAL, OP_JALR}) ? ITYPE_CTRL
			: ITYPE_ALU;
		instr.branch = instr.opcode == OP_BRANCH;
		instr.jalr = instr.opcode == OP_JALR;
		instr.lui = instr.opcode == OP_LUI;
		instr.auipc = instr.opcode == OP_AUIPC;
		instr.u_type = instr.lui || instr.auipc;
		instr.alloc_rob = instr.opcode != OP_BUBBLE;
		instr.alloc_ldq = instr.opcode == OP_LOAD;
		instr.alloc_stq = instr.opcode == OP_STORE;
		// a bubble is never valid
		instr.valid = instr.opcode != OP_BUBBLE && !biased(mode == 1 ? 1 : 3);
		instr.flush = biased(mode == 1 ? 2 : 4);
		instr.pc = take_bits(32) & 32'hffff_fffe;
		instr.immediate = take_bits(32);
		instr.length = !biased(2);
		instr.rs1 = take_bits(32);
		instr.rs1_rob_tag = ROB_TAG_WIDTH'(take_bits(ROB_TAG_WIDTH));
		instr.rs1_rob_tag_valid = biased(1);
		instr.rs2 = take_bits(32);
		instr.rs2_rob_tag = ROB_TAG_WIDTH'(take_bits(ROB_TAG_WIDTH));
		instr.rs2_rob_tag_valid = biased(1);
		status.rob_full = biased(mode == 2 ? 2 : 4);
		status.ldq_full = biased(mode == 2 ? 2 : 4);
		status.stq_full = biased(mode == 2 ? 2 : 4);
		for (int i = 0; i < N_ALU_RS; i++) begin
			status.alu_rs_busy[i] = !biased(mode == 2 ? 3 : 1);
		end
		for (int i = 0; i < N_AGU_RS; i++) begin
			status.agu_rs_busy[i] = !biased(mode == 2 ? 3 : 1);
		end
		for (int i = 0; i < N_BRANCH_RS; i++) begin
			status.branch_rs_busy[i] = !biased(mode == 2 ? 3 : 1);
		end
		for (int i = 0; i < ROB_SIZE; i++) begin
			rob.value[i] = take_bits(32);
			rob.data_ready[i] = biased(1);
		end
	endtask

	// one-hot of the lowest index that is not busy, searched over n stations
	function automatic logic [N_ALU_RS-1:0] first_free(input logic [N_ALU_RS-1:0] busy,
		input int n);
		for (int i = 0; i < n; i++) begin
			if (!busy[i]) begin
				return N_ALU_RS'(1) << i;
			end
		end
		return '0;
	endfunction

	// {wait, tag, value} for one source
	function automatic logic [XLEN+ROB_TAG_WIDTH:0] resolve(input logic [XLEN-1:0] val,
		input logic [ROB_TAG_WIDTH-1:0] tag, input logic tag_valid);
		if (!tag_valid) begin
			return {1'b0, {ROB_TAG_WIDTH{1'b0}}, val};
		end
		if (rob.data_ready[tag]) begin
			return {1'b0, {ROB_TAG_WIDTH{1'b0}}, rob.value[tag]};
		end
		return {1'b1, tag, {XLEN{1'b0}}};
	endfunction

	// reference model for the inputs as now driven
	task automatic predict(output logic exp_stall, output dispatch_t e);
		logic blocked;
		logic jal;
		logic store_ready;
		logic [XLEN+ROB_TAG_WIDTH:0] src1;
		logic [XLEN+ROB_TAG_WIDTH:0] src2;
		e = '0;
		blocked = (instr.alloc_rob && status.rob_full) || (instr.alloc_ldq && status.ldq_full)
			|| (instr.alloc_stq && status.stq_full);
		case (instr.instruction_type)
			ITYPE_ALU: blocked |= !instr.u_type && (&status.alu_rs_busy);
			ITYPE_CTRL: blocked |= (instr.branch || instr.jalr) && (&status.branch_rs_busy);
			default: blocked |= &status.agu_rs_busy;
		endcase
		exp_stall = instr.valid && !instr.flush && blocked;
		if (instr.valid && !instr.flush && !blocked) begin
			e.route.alloc_rob = instr.alloc_rob;
			e.route.alloc_ldq = instr.alloc_ldq;
			e.route.alloc_stq = instr.alloc_stq;
			if (instr.instruction_type == ITYPE_ALU && !instr.u_type) begin
				e.route.alu_rs_route = first_free(status.alu_rs_busy, N_ALU_RS);
			end else if (instr.instruction_type[1]) begin
				e.route.agu_rs_route =
					N_AGU_RS'(first_free(N_ALU_RS'(status.agu_rs_busy), N_AGU_RS));
			end else if (instr.instruction_type == ITYPE_CTRL
				&& (instr.branch || instr.jalr)) begin
				e.route.branch_rs_route =
					N_BRANCH_RS'(first_free(N_ALU_RS'(status.branch_rs_busy), N_BRANCH_RS));
			end
		end
		src1 = resolve(instr.rs1, instr.rs1_rob_tag, instr.rs1_rob_tag_valid);
		src2 = resolve(instr.rs2, instr.rs2_rob_tag, instr.rs2_rob_tag_valid);
		if (instr.opcode == OP_JAL || instr.opcode == OP_AUIPC) begin
			e.ops.v1 = instr.pc;
		end else if (instr.opcode != OP_LUI && instr.opcode != OP_BUBBLE) begin
			{e.ops.q1_valid, e.ops.q1, e.ops.v1} = src1;
		end
		if (instr.opcode == OP_R_TYPE || instr.opcode == OP_BRANCH) begin
			{e.ops.q2_valid, e.ops.q2, e.ops.v2} = src2;
		end else if (instr.opcode != OP_BUBBLE) begin
			e.ops.v2 = instr.immediate;
		end
		// starting ROB value and completion
		jal = instr.instruction_type == ITYPE_CTRL && !instr.branch && !instr.jalr;
		store_ready = instr.instruction_type == ITYPE_STORE && !instr.rs2_rob_tag_valid;
		if (instr.instruction_type == ITYPE_CTRL && !instr.branch) begin
			e.rob_value = instr.pc + (instr.length ? 32'd4 : 32'd2);
		end else if (instr.lui) begin
			e.rob_value = instr.immediate;
		end else if (instr.auipc) begin
			e.rob_value = instr.pc + instr.immediate;
		end else if (store_ready) begin
			e.rob_value = instr.rs2;
		end
		e.rob_data_ready = e.route.alloc_rob && (jal || instr.lui || instr.auipc || store_ready);
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] got);
		test_checks++;
		assert (got === exp) else begin
			$display("FAILED at %0.1f ns: %s expected %h, got %h", $realtime, name, exp, got);
			test_errors++;
		end
	endtask

	task automatic check_dispatch(input dispatch_t e);
		check_value("dispatch.route", 128'(e.route), 128'(dispatch.route));
		check_value("dispatch.ops", 128'(e.ops), 128'(dispatch.ops));
		check_value("dispatch.rob_value", 128'(e.rob_value), 128'(dispatch.rob_value));
		check_value("dispatch.rob_data_ready", 128'(e.rob_data_ready),
			128'(dispatch.rob_data_ready));
	endtask

	task automatic finish_test(input string name);
		$display("test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		tests_run++;
		test_checks = 0;
		test_errors = 0;
	endtask

	// record must stay empty through reset and at its release
	task automatic run_reset();
		rst_n = 1'b0;
		for (int k = 0; k <= RESET_CYCLES; k++) begin
			@(posedge clk);
			#0.5;
			if (k == RESET_CYCLES) begin
				rst_n = 1'b1;
			end
			check_value("dispatch.route", 128'(0), 128'(dispatch.route));
			check_value("dispatch.rob_data_ready", 128'(0), 128'(dispatch.rob_data_ready));
			make_inputs(0);
		end
		finish_test("reset");
	endtask

	// dispatch checked just after the edge, stall late in the cycle
	task automatic run_test(input string name, input int cycles, input int mode);
		dispatch_t exp_q;
		logic exp_stall;
		for (int k = 0; k <= cycles; k++) begin
			@(posedge clk);
			#0.5;
			if (k > 0) begin
				check_dispatch(exp_q);
			end
			if (k < cycles) begin
				make_inputs(mode);
				predict(exp_stall, exp_q);
				#2;
				check_value("stall", 128'(exp_stall), 128'(stall));
			end
		end
		finish_test(name);
	endtask

	initial begin
		rst_n = 1'b0;
		instr = '0;
		status = '0;
		rob = '0;
		run_reset();
		run_test("mixed", N_MIXED, 0);
		run_test("kill", N_KILL, 1);
		run_test("stall", N_STALL, 2);
		$display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule
